/* src/grom_bus_pkg.sv */
package grom_bus_pkg;

	localparam int ADDR_W = 12;
	localparam int DATA_W = 8;
	localparam int SEG_W  = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEG_W-1:0]  seg_t;   // Top nibble of a data address

	localparam addr_t PC_RESET = addr_t'(0);

endpackage

/* src/grom_isa_pkg.sv */
package grom_isa_pkg;

	localparam int NUM_REGS = 4;

	typedef logic [1:0] reg_sel_t;

	// Single-byte groups, bits 6:4
	localparam logic [2:0] GRP_MOV     = 3'b000;
	localparam logic [2:0] GRP_ARITH   = 3'b001;
	localparam logic [2:0] GRP_LOGIC   = 3'b010;
	localparam logic [2:0] GRP_INCDEC  = 3'b011;
	localparam logic [2:0] GRP_LOADR   = 3'b101;
	localparam logic [2:0] GRP_STORER  = 3'b110;
	localparam logic [2:0] GRP_SPECIAL = 3'b111;

	// Two-byte groups
	localparam logic [2:0] GRP_JR      = 3'b000;
	localparam logic [2:0] GRP_JUMP    = 3'b001;
	localparam logic [2:0] GRP_SEGIMM  = 3'b110;
	localparam logic [2:0] GRP_IMM     = 3'b111;

	localparam logic [1:0] SPC_MOV_DS  = 2'b01;  // Special, dst field
	localparam logic [1:0] SPC_MISC    = 2'b11;
	localparam logic [1:0] SPC_HALT    = 2'b11;  // Special misc, src field
	localparam logic [1:0] SEG_DS      = 2'b01;  // Segment immediate, src field
	localparam logic [1:0] IMM_MOV     = 2'b00;
	localparam logic [1:0] IMM_LOAD    = 2'b01;
	localparam logic [1:0] IMM_STORE   = 2'b10;

	localparam logic [2:0] COND_ALWAYS = 3'b000;
	localparam logic [2:0] COND_C      = 3'b001;
	localparam logic [2:0] COND_NC     = 3'b010;
	localparam logic [2:0] COND_M      = 3'b011;
	localparam logic [2:0] COND_P      = 3'b100;
	localparam logic [2:0] COND_Z      = 3'b101;
	localparam logic [2:0] COND_NZ     = 3'b110;

	// Grouped by four so the dst field selects within a group
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_ADC = 4'd2,
		ALU_SBC = 4'd3,
		ALU_AND = 4'd4,
		ALU_OR  = 4'd5,
		ALU_NOT = 4'd6,
		ALU_XOR = 4'd7,
		ALU_INC = 4'd8,
		ALU_DEC = 4'd9,
		ALU_CMP = 4'd10,
		ALU_TST = 4'd11
	} alu_op_t;

	typedef struct packed {
		logic       long_f;
		logic [2:0] grp;
		logic [1:0] dst;   // Register or sub-operation
		reg_sel_t   src;
	} instr_reg_t;

	typedef struct packed {
		logic       long_f;
		logic [2:0] grp;
		logic [3:0] tgt;   // Relative flag and condition, or jump address high nibble
	} instr_tgt_t;

	typedef union packed {
		instr_reg_t r;
		instr_tgt_t t;
	} instr_t;

	// Controller states
	localparam logic [3:0] ST_FETCH       = 4'd0;
	localparam logic [3:0] ST_FETCH_WAIT  = 4'd1;
	localparam logic [3:0] ST_FETCH_LATCH = 4'd2;
	localparam logic [3:0] ST_EXEC        = 4'd3;
	localparam logic [3:0] ST_IMM_WAIT    = 4'd4;
	localparam logic [3:0] ST_IMM_LATCH   = 4'd5;
	localparam logic [3:0] ST_EXEC_DBL    = 4'd6;
	localparam logic [3:0] ST_LOAD_WAIT   = 4'd7;
	localparam logic [3:0] ST_LOAD_WRITE  = 4'd8;
	localparam logic [3:0] ST_ALU_WAIT    = 4'd9;
	localparam logic [3:0] ST_ALU_WRITE   = 4'd10;
	localparam logic [3:0] ST_HALTED      = 4'd11;

endpackage

/* src/grom_alu.sv */
`timescale 1ns/1ps

module grom_alu
	import grom_bus_pkg::*;
	import grom_isa_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  data_t   alu_a,
	input  data_t   alu_b,
	input  alu_op_t alu_op,
	input  logic    alu_go,
	output data_t   alu_result,
	output logic    carry,
	output logic    zero,
	output logic    sign
);

	logic [DATA_W:0] wide;   // Carry or borrow in the top bit
	logic [DATA_W:0] a_ext;
	logic [DATA_W:0] b_ext;
	logic [DATA_W:0] c_ext;

	assign a_ext = {1'b0, alu_a};
	assign b_ext = {1'b0, alu_b};
	assign c_ext = {{DATA_W{1'b0}}, carry};

	always_comb
	begin
		case (alu_op)
			ALU_ADD:          wide = a_ext + b_ext;
			ALU_SUB, ALU_CMP: wide = a_ext - b_ext;
			ALU_ADC:          wide = a_ext + b_ext + c_ext;
			ALU_SBC:          wide = a_ext - b_ext - c_ext;
			ALU_AND, ALU_TST: wide = a_ext & b_ext;
			ALU_OR:           wide = a_ext | b_ext;
			ALU_NOT:          wide = {1'b0, ~alu_b};
			ALU_XOR:          wide = a_ext ^ b_ext;
			ALU_INC:          wide = b_ext + (DATA_W+1)'(1);
			ALU_DEC:          wide = b_ext - (DATA_W+1)'(1);
			default:          wide = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			alu_result <= '0;
			carry      <= 1'b0;
			zero       <= 1'b0;
			sign       <= 1'b0;
		end
		else if (alu_go)
		begin
			alu_result <= wide[DATA_W-1:0];
			carry      <= wide[DATA_W];
			zero       <= (wide[DATA_W-1:0] == '0);
			sign       <= wide[DATA_W-1];
		end
	end

endmodule

/* src/grom_regfile.sv */
`timescale 1ns/1ps

module grom_regfile
	import grom_bus_pkg::*;
	import grom_isa_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t rd_sel_a,
	input  reg_sel_t rd_sel_b,
	output data_t    rd_data_a,
	output data_t    rd_data_b,
	input  logic     wr_en,
	input  reg_sel_t wr_sel,
	input  data_t    wr_data,
	input  logic     ds_wr_en,
	input  seg_t     ds_data,
	output seg_t     ds
);

	data_t regs [NUM_REGS];   // R0 to R3

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
			ds <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				regs[wr_sel] <= wr_data;
			end
			if (ds_wr_en)
			begin
				ds <= ds_data;
			end
		end
	end

	assign rd_data_a = regs[rd_sel_a];
	assign rd_data_b = regs[rd_sel_b];

endmodule

/* src/grom_control.sv */
`timescale 1ns/1ps

module grom_control
	import grom_bus_pkg::*;
	import grom_isa_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	output addr_t    addr,
	input  data_t    data_in,
	output data_t    data_out,
	output logic     we,
	output logic     hlt,
	output reg_sel_t rd_sel_a,
	output reg_sel_t rd_sel_b,
	input  data_t    rd_data_a,
	input  data_t    rd_data_b,
	output logic     wr_en,
	output reg_sel_t wr_sel,
	output data_t    wr_data,
	output logic     ds_wr_en,
	output seg_t     ds_data,
	input  seg_t     ds,
	output data_t    alu_a,
	output data_t    alu_b,
	output alu_op_t  alu_op,
	output logic     alu_go,
	input  data_t    alu_result,
	input  logic     carry,
	input  logic     zero,
	input  logic     sign
);

	addr_t      pc;
	instr_t     instr;
	data_t      imm;       // Second byte of a long instruction
	reg_sel_t   tgt_reg;   // Destination of a load or ALU result
	logic [3:0] state;

	logic  alu_grp;
	logic  jr_taken;
	addr_t jr_offset;

	function automatic logic cond_met(input logic [2:0] cond, input logic c,
		input logic z, input logic s);
		case (cond)
			COND_ALWAYS: return 1'b1;
			COND_C:      return c;
			COND_NC:     return !c;
			COND_M:      return s;
			COND_P:      return !s;
			COND_Z:      return z;
			COND_NZ:     return !z;
			default:     return 1'b0;
		endcase
	endfunction

	assign alu_grp = !instr.r.long_f && (instr.r.grp == GRP_ARITH ||
		instr.r.grp == GRP_LOGIC || instr.r.grp == GRP_INCDEC);

	// ALU groups always take R0 as first operand
	assign rd_sel_a = alu_grp ? reg_sel_t'(0) : instr.r.dst;
	assign rd_sel_b = instr.r.src;

	assign jr_offset = {{(ADDR_W-DATA_W){imm[DATA_W-1]}}, imm};
	assign jr_taken  = instr.t.tgt[3] && cond_met(instr.t.tgt[2:0], carry, zero, sign);

	assign hlt = (state == ST_HALTED);

	// Register file and DS writes
	always_comb
	begin
		wr_en    = 1'b0;
		wr_sel   = tgt_reg;
		wr_data  = alu_result;
		ds_wr_en = 1'b0;
		ds_data  = rd_data_b[SEG_W-1:0];
		case (state)
			ST_EXEC:
				if (!instr.r.long_f && instr.r.grp == GRP_MOV)
				begin
					wr_en   = 1'b1;
					wr_sel  = instr.r.dst;
					wr_data = rd_data_b;
				end
				else if (!instr.r.long_f && instr.r.grp == GRP_SPECIAL &&
					instr.r.dst == SPC_MOV_DS)
				begin
					ds_wr_en = 1'b1;
				end
			ST_EXEC_DBL:
				if (instr.r.grp == GRP_IMM && instr.r.dst == IMM_MOV)
				begin
					wr_en   = 1'b1;
					wr_sel  = instr.r.src;
					wr_data = imm;
				end
				else if (instr.r.grp == GRP_SEGIMM && instr.r.src == SEG_DS)
				begin
					ds_wr_en = 1'b1;
					ds_data  = imm[SEG_W-1:0];
				end
			ST_LOAD_WRITE:
			begin
				wr_en   = 1'b1;
				wr_data = data_in;
			end
			ST_ALU_WRITE:
				wr_en = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= ST_FETCH;
			pc     <= PC_RESET;
			addr   <= PC_RESET;
			we     <= 1'b0;
			alu_go <= 1'b0;
		end
		else
		begin
			we     <= 1'b0;   // Strobes last one cycle
			alu_go <= 1'b0;
			case (state)
				ST_FETCH:
				begin
					addr  <= pc;
					state <= ST_FETCH_WAIT;
				end
				ST_FETCH_WAIT:
					state <= ST_FETCH_LATCH;
				ST_FETCH_LATCH:
				begin
					instr <= data_in;
					pc    <= pc + 1'b1;
					state <= ST_EXEC;
				end
				ST_EXEC:
					if (instr.r.long_f)
					begin
						addr  <= pc;
						pc    <= pc + 1'b1;
						state <= ST_IMM_WAIT;
					end
					else
					begin
						state <= ST_FETCH;
						case (instr.r.grp)
							GRP_ARITH, GRP_LOGIC, GRP_INCDEC:
							begin
								alu_a   <= rd_data_a;
								alu_b   <= rd_data_b;
								alu_op  <= alu_op_t'({instr.r.grp[1:0] - 2'd1, instr.r.dst});
								alu_go  <= 1'b1;
								tgt_reg <= (instr.r.grp == GRP_INCDEC) ? instr.r.src : reg_sel_t'(0);
								// CMP and TST only set flags
								if (!(instr.r.grp == GRP_INCDEC && instr.r.dst[1]))
								begin
									state <= ST_ALU_WAIT;
								end
							end
							GRP_LOADR:
							begin
								addr    <= {ds, rd_data_b};
								tgt_reg <= instr.r.dst;
								state   <= ST_LOAD_WAIT;
							end
							GRP_STORER:
							begin
								addr     <= {ds, rd_data_a};
								data_out <= rd_data_b;
								we       <= 1'b1;
							end
							GRP_SPECIAL:
								if (instr.r.dst == SPC_MISC && instr.r.src == SPC_HALT)
								begin
									state <= ST_HALTED;
								end
							default: ;   // MOV goes through the write port
						endcase
					end
				ST_IMM_WAIT:
					state <= ST_IMM_LATCH;
				ST_IMM_LATCH:
				begin
					imm   <= data_in;
					state <= ST_EXEC_DBL;
				end
				ST_EXEC_DBL:
				begin
					state <= ST_FETCH;
					case (instr.t.grp)
						GRP_JR:
							if (jr_taken)
							begin
								pc <= pc + jr_offset;   // pc already past both bytes
							end
						GRP_JUMP:
							pc <= {instr.t.tgt, imm};
						GRP_IMM:
							case (instr.r.dst)
								IMM_LOAD:
								begin
									addr    <= {ds, imm};
									tgt_reg <= instr.r.src;
									state   <= ST_LOAD_WAIT;
								end
								IMM_STORE:
								begin
									addr     <= {ds, imm};
									data_out <= rd_data_b;
									we       <= 1'b1;
								end
								default: ;
							endcase
						default: ;
					endcase
				end
				ST_LOAD_WAIT:
					state <= ST_LOAD_WRITE;
				ST_LOAD_WRITE:
					state <= ST_FETCH;
				ST_ALU_WAIT:
					state <= ST_ALU_WRITE;
				ST_ALU_WRITE:
					state <= ST_FETCH;
				ST_HALTED:
					state <= ST_HALTED;   // Only reset leaves
				default:
					state <= ST_FETCH;
			endcase
		end
	end

endmodule

/* src/grom_cpu.sv */
`timescale 1ns/1ps

module grom_cpu
	import grom_bus_pkg::*;
	import grom_isa_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	output addr_t addr,
	input  data_t data_in,
	output data_t data_out,
	output logic  we,
	output logic  hlt
);

	reg_sel_t rd_sel_a;
	reg_sel_t rd_sel_b;
	data_t    rd_data_a;
	data_t    rd_data_b;
	logic     wr_en;
	reg_sel_t wr_sel;
	data_t    wr_data;
	logic     ds_wr_en;
	seg_t     ds_data;
	seg_t     ds;

	data_t    alu_a;
	data_t    alu_b;
	alu_op_t  alu_op;
	logic     alu_go;
	data_t    alu_result;
	logic     carry;
	logic     zero;
	logic     sign;

	grom_control u_control (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.data_in    (data_in),
		.data_out   (data_out),
		.we         (we),
		.hlt        (hlt),
		.rd_sel_a   (rd_sel_a),
		.rd_sel_b   (rd_sel_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.wr_en      (wr_en),
		.wr_sel     (wr_sel),
		.wr_data    (wr_data),
		.ds_wr_en   (ds_wr_en),
		.ds_data    (ds_data),
		.ds         (ds),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_op     (alu_op),
		.alu_go     (alu_go),
		.alu_result (alu_result),
		.carry      (carry),
		.zero       (zero),
		.sign       (sign)
	);

	grom_regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_sel_a  (rd_sel_a),
		.rd_sel_b  (rd_sel_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_sel    (wr_sel),
		.wr_data   (wr_data),
		.ds_wr_en  (ds_wr_en),
		.ds_data   (ds_data),
		.ds        (ds)
	);

	grom_alu u_alu (
		.clk        (clk),
		.reset      (reset),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_op     (alu_op),
		.alu_go     (alu_go),
		.alu_result (alu_result),
		.carry      (carry),
		.zero       (zero),
		.sign       (sign)
	);

endmodule

/* test/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory
	import grom_bus_pkg::*;
(
	input  logic         clk,
	input  logic         load,
	input  logic [127:0] image,   // Program bytes, address 0 in the low byte
	input  addr_t        addr,
	input  data_t        wdata,
	input  logic         we,
	output data_t        rdata,
	output addr_t        last_addr,
	output data_t        last_data,
	output int           wr_count
);

	data_t mem [2**ADDR_W];

	always @(posedge clk)
	begin
		if (load)
		begin
			for (int i = 0; i < 2**ADDR_W; i++)
			begin
				mem[i] <= data_t'(i) ^ data_t'(i >> 4) ^ 8'h5a;
			end
			for (int i = 0; i < 16; i++)
			begin
				mem[i] <= image[8*i +: 8];   // Later assignment wins over the fill
			end
			last_addr <= '0;
			last_data <= '0;
			wr_count  <= 0;
		end
		else if (we)
		begin
			mem[addr] <= wdata;
			last_addr <= addr;
			last_data <= wdata;
			wr_count  <= wr_count + 1;
		end
		rdata <= mem[addr];
	end

endmodule

/* test/tb_grom_cpu.sv */
`timescale 1ns/1ps

module tb_grom_cpu
	import grom_bus_pkg::*;
	import grom_isa_pkg::*;
;

	logic         clk;
	logic         reset;
	addr_t        addr;
	data_t        data_in;
	data_t        data_out;
	logic         we;
	logic         hlt;
	logic         load;
	logic [127:0] image;
	addr_t        last_addr;
	data_t        last_data;
	int           wr_count;

	string        t_name [32];
	logic [127:0] t_prog [32];
	addr_t        t_addr [32];
	data_t        t_data [32];
	int           n_tests;
	int           pos;

	logic [31:0]  lcg;
	data_t        opa;
	data_t        opb;
	data_t        cx;
	data_t        cy;
	data_t        cin;   // Carry left by the CMP

	grom_cpu DUT (
		.clk      (clk),
		.reset    (reset),
		.addr     (addr),
		.data_in  (data_in),
		.data_out (data_out),
		.we       (we),
		.hlt      (hlt)
	);

	tb_memory memory (
		.clk       (clk),
		.load      (load),
		.image     (image),
		.addr      (addr),
		.wdata     (data_out),
		.we        (we),
		.rdata     (data_in),
		.last_addr (last_addr),
		.last_data (last_data),
		.wr_count  (wr_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic data_t rand_byte();
		lcg = lcg * 32'd1664525 + 32'd1013904223;
		return lcg[23:16];
	endfunction

	// Keeps stores clear of the program bytes
	function automatic data_t rand_addr();
		return rand_byte() | 8'h40;
	endfunction

	function automatic data_t halt_op();
		return {1'b0, GRP_SPECIAL, SPC_MISC, SPC_HALT};
	endfunction

	task automatic start_case(input string name);
		t_name[n_tests] = name;
		t_prog[n_tests] = {16{halt_op()}};
		pos = 0;
	endtask

	task automatic emit(input data_t b);
		t_prog[n_tests][8*pos +: 8] = b;
		pos++;
	endtask

	task automatic finish_case(input addr_t a, input data_t d);
		t_addr[n_tests] = a;
		t_data[n_tests] = d;
		n_tests++;
	endtask

	task automatic move_imm(input reg_sel_t r, input data_t v);
		emit({1'b1, GRP_IMM, IMM_MOV, r});
		emit(v);
	endtask

	task automatic store_direct(input reg_sel_t r, input data_t a);
		emit({1'b1, GRP_IMM, IMM_STORE, r});
		emit(a);
	endtask

	task automatic draw_operands();
		opa = rand_byte();
		opb = rand_byte();
		cx  = rand_byte() & 8'h7f;
		cy  = rand_byte() | 8'h80;   // Above cx so the CMP always borrows
		cin = (cx < cy) ? 8'd1 : 8'd0;   // Borrow of cx - cy
	endtask

	task automatic alu_case(input string name, input logic [2:0] grp, input logic [1:0] sub,
		input reg_sel_t res, input data_t expected);
		data_t sa;
		sa = rand_addr();
		start_case(name);
		move_imm(2'd0, cx);
		move_imm(2'd2, cy);
		emit({1'b0, GRP_INCDEC, 2'b10, 2'd2});   // CMP R2
		move_imm(2'd0, opa);
		move_imm(2'd1, opb);
		emit({1'b0, grp, sub, 2'd1});
		store_direct(res, sa);
		emit(halt_op());
		finish_case({4'h0, sa}, expected);
	endtask

	task automatic indirect_case(input string name, input logic by_reg);
		data_t v;
		data_t p;
		data_t q;
		data_t seg;
		v   = rand_byte();
		p   = rand_addr();
		q   = p ^ 8'h01;
		seg = rand_byte() | 8'h01;   // Odd keeps DS off its reset value
		start_case(name);
		if (by_reg)
		begin
			move_imm(2'd0, seg);
			emit({1'b0, GRP_SPECIAL, SPC_MOV_DS, 2'd0});
		end
		else
		begin
			emit({1'b1, GRP_SEGIMM, 2'b00, SEG_DS});
			emit(seg);
		end
		move_imm(2'd1, p);
		move_imm(2'd2, v);
		emit({1'b0, GRP_STORER, 2'd1, 2'd2});   // [DS:R1] <= R2
		emit({1'b0, GRP_LOADR, 2'd3, 2'd1});    // R3 <= [DS:R1]
		move_imm(2'd1, q);
		emit({1'b0, GRP_STORER, 2'd1, 2'd3});
		emit(halt_op());
		finish_case({seg[3:0], q}, v);
	endtask

	// Taken path stores y and the fall-through path stores ~y
	task automatic branch_case(input string name, input logic [2:0] cond, input logic equal,
		input logic taken);
		data_t x;
		data_t y;
		data_t sa;
		x  = rand_byte();
		y  = equal ? x : x ^ 8'h5a;
		sa = rand_addr();
		start_case(name);
		move_imm(2'd0, x);
		move_imm(2'd1, y);
		move_imm(2'd2, ~y);
		emit({1'b0, GRP_INCDEC, 2'b10, 2'd1});   // CMP R1
		emit({1'b1, GRP_JR, 1'b1, cond});
		emit(8'd3);
		store_direct(2'd2, sa);
		emit(halt_op());
		store_direct(2'd1, sa);
		emit(halt_op());
		finish_case({4'h0, sa}, taken ? y : ~y);
	endtask

	task automatic build_table();
		data_t v;
		data_t sa;
		data_t seg;
		n_tests = 0;
		v   = rand_byte();
		sa  = rand_addr();
		seg = rand_byte() | 8'h01;
		start_case("mov_store");
		move_imm(2'd2, v);
		emit({1'b0, GRP_MOV, 2'd3, 2'd2});
		emit({1'b1, GRP_SEGIMM, 2'b00, SEG_DS});
		emit(seg);
		store_direct(2'd3, sa);
		emit(halt_op());
		finish_case({seg[3:0], sa}, v);
		draw_operands();
		alu_case("add", GRP_ARITH, 2'd0, 2'd0, opa + opb);
		draw_operands();
		alu_case("sub", GRP_ARITH, 2'd1, 2'd0, opa - opb);
		draw_operands();
		alu_case("adc", GRP_ARITH, 2'd2, 2'd0, opa + opb + cin);
		draw_operands();
		alu_case("sbc", GRP_ARITH, 2'd3, 2'd0, opa - opb - cin);
		draw_operands();
		alu_case("and", GRP_LOGIC, 2'd0, 2'd0, opa & opb);
		draw_operands();
		alu_case("or", GRP_LOGIC, 2'd1, 2'd0, opa | opb);
		draw_operands();
		alu_case("not", GRP_LOGIC, 2'd2, 2'd0, ~opb);
		draw_operands();
		alu_case("xor", GRP_LOGIC, 2'd3, 2'd0, opa ^ opb);
		draw_operands();
		alu_case("inc", GRP_INCDEC, 2'd0, 2'd1, opb + 8'd1);
		draw_operands();
		alu_case("dec", GRP_INCDEC, 2'd1, 2'd1, opb - 8'd1);
		indirect_case("indirect_ds_imm", 1'b0);
		indirect_case("indirect_ds_reg", 1'b1);
		v  = rand_byte();
		sa = rand_addr();
		start_case("jump");
		move_imm(2'd1, v);
		move_imm(2'd2, ~v);
		store_direct(2'd1, sa);
		emit({1'b1, GRP_JUMP, 4'h0});
		emit(8'd10);
		store_direct(2'd2, sa);   // Skipped by the jump
		emit(halt_op());
		finish_case({4'h0, sa}, v);
		branch_case("jrz_taken", COND_Z, 1'b1, 1'b1);
		branch_case("jrz_fall", COND_Z, 1'b0, 1'b0);
		branch_case("jrnz_taken", COND_NZ, 1'b0, 1'b1);
		branch_case("jrnz_fall", COND_NZ, 1'b1, 1'b0);
		v  = rand_byte();
		sa = rand_addr();
		start_case("halt");
		move_imm(2'd1, v);
		store_direct(2'd1, sa);
		emit(halt_op());
		store_direct(2'd2, sa ^ 8'h01);   // Never reached
		finish_case({4'h0, sa}, v);
	endtask

	task automatic apply_reset(input logic [127:0] prog);
		@(negedge clk);
		reset = 1'b1;
		load  = 1'b1;
		image = prog;
		@(negedge clk);
		load = 1'b0;
		repeat (9) @(negedge clk);
		reset = 1'b0;
	endtask

	initial
	begin
		int failed;
		int cycles;
		int writes;
		reset  = 1'b1;
		load   = 1'b0;
		image  = '0;
		lcg    = 32'h31b4_377d;
		failed = 0;
		build_table();
		for (int t = 0; t < n_tests; t++)
		begin
			apply_reset(t_prog[t]);
			cycles = 0;
			while (!hlt && cycles < 2000)
			begin
				@(negedge clk);
				cycles++;
			end
			if (!hlt)
			begin
				$display("%s: hlt did not rise within 2000 cycles", t_name[t]);
				failed++;
			end
			else if (wr_count == 0)
			begin
				$display("%s: no memory write before halt", t_name[t]);
				failed++;
			end
			else if (last_addr != t_addr[t] || last_data != t_data[t])
			begin
				$display("ERROR %s: expected %h at %h, actual %h at %h", t_name[t],
					t_data[t], t_addr[t], last_data, last_addr);
				failed++;
			end
			else
			begin
				writes = wr_count;
				cycles = 0;
				while (hlt && wr_count == writes && cycles < 50)
				begin
					@(negedge clk);
					cycles++;
				end
				if (!hlt || wr_count != writes)
				begin
					$display("%s: memory written or hlt dropped after halt", t_name[t]);
					failed++;
				end
				else
				begin
					$display("%s: ok", t_name[t]);
				end
			end
		end
		$display("%0d tests, %0d passed, %0d failed", n_tests, n_tests - failed, failed);
		if (failed == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
src/grom_bus_pkg.sv
src/grom_isa_pkg.sv
src/grom_alu.sv
src/grom_regfile.sv
src/grom_control.sv
src/grom_cpu.sv
test/tb_memory.sv
test/tb_grom_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_grom_cpu -o tb_grom_cpu

./obj_dir/tb_grom_cpu | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
	exit 0
else
	exit 1
fi
